// File: dv/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb;

  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY = 10;
  localparam int HALT_HOLD_CYCLES = 4;

  logic clk;
  logic rst;
  logic imemWrEn;
  cpuPkg::memIdx_t imemWrAddr;
  cpuPkg::word_t imemWrData;
  cpuPkg::regAddr_t dbgRegAddr;
  cpuPkg::word_t dbgRegData;
  logic ecall;

  // current test as parsed from the cases file
  logic [8*32-1:0] testName;
  cpuPkg::word_t progWords[$];
  cpuPkg::regAddr_t expRegs[$];
  cpuPkg::word_t expVals[$];

  int testErrors;
  int testsRun;
  int testsFailed;
  int setupErrors;
  logic aborted;

  tbClock #(.PERIOD_NS(100)) i_tbClock (.clk(clk));

  cpuTop i_cpuTop (
    .clk(clk),
    .rst(rst),
    .imemWrEn_i(imemWrEn),
    .imemWrAddr_i(imemWrAddr),
    .imemWrData_i(imemWrData),
    .dbgRegAddr_i(dbgRegAddr),
    .dbgRegData_o(dbgRegData),
    .ecall_o(ecall)
  );

  // ==================================================
  // helpers
  // ==================================================
  // inputs change and outputs are read a little after the edge
  task automatic nextCycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic checkEcall(input logic expected);
    assert (ecall === expected) else begin
      $display("Fail at %0t ns: ecall_o expected %b actual %b", $time, expected, ecall);
      testErrors++;
    end
  endtask

  // walk the expected registers through the debug port
  task automatic checkRegisters();
    int i;
    for (i = 0; i < expRegs.size(); i++) begin
      dbgRegAddr = expRegs[i];
      nextCycle();
      assert (dbgRegData === expVals[i]) else begin
        $display("Fail at %0t ns: x%0d expected %08h actual %08h", $time, expRegs[i],
                 expVals[i], dbgRegData);
        testErrors++;
      end
      checkEcall(1'b1);
    end
  endtask

  task automatic runTest();
    int i;
    int loadCycles;
    int limit;
    int waited;
    testErrors = 0;
    loadCycles = (progWords.size() > RESET_CYCLES) ? progWords.size() : RESET_CYCLES;
    rst = 1'b1;
    // program goes in while the core sits in reset
    for (i = 0; i < loadCycles; i++) begin
      if (i < progWords.size()) begin
        imemWrEn = 1'b1;
        imemWrAddr = i[7:0];
        imemWrData = progWords[i];
      end else begin
        imemWrEn = 1'b0;
      end
      nextCycle();
      checkEcall(1'b0);
    end
    imemWrEn = 1'b0;
    rst = 1'b0;

    limit = 8 * progWords.size() + 50;
    waited = 0;
    while (ecall !== 1'b1 && waited < limit) begin
      nextCycle();
      waited++;
    end

    if (ecall !== 1'b1) begin
      $display("test %0s: ecall never came within %0d cycles, stopping", testName, limit);
      testErrors++;
      aborted = 1'b1;
    end else begin
      checkRegisters();
      // halt holds with no further input
      for (i = 0; i < HALT_HOLD_CYCLES; i++) begin
        nextCycle();
        checkEcall(1'b1);
      end
    end

    testsRun++;
    if (testErrors == 0) begin
      $display("test %0s: passed after %0d cycles", testName, waited);
    end else begin
      testsFailed++;
      $display("test %0s: failed with %0d errors", testName, testErrors);
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int fd;
    int rc;
    int regNum;
    cpuPkg::word_t value;
    logic [8*32-1:0] tok;
    logic [8*256-1:0] restOfLine;
    logic inExpect;
    rst = 1'b1;
    imemWrEn = 1'b0;
    imemWrAddr = '0;
    imemWrData = '0;
    dbgRegAddr = '0;
    testName = "none";
    testErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    setupErrors = 0;
    aborted = 1'b0;
    inExpect = 1'b0;

    fd = $fopen("dv/programCases.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/programCases.txt");
      setupErrors++;
    end else begin
      while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          rc = $fgets(restOfLine, fd);
        end else if (tok == "T") begin
          rc = $fscanf(fd, "%s", testName);
          progWords.delete();
          expRegs.delete();
          expVals.delete();
          inExpect = 1'b0;
        end else if (tok == "P") begin
          inExpect = 1'b0;
        end else if (tok == "E") begin
          inExpect = 1'b1;
        end else if (tok == "X") begin
          runTest();
        end else if (inExpect) begin
          // register index, then its value
          rc = $sscanf(tok, "%d", regNum);
          rc = rc + $fscanf(fd, "%h", value);
          if (rc != 2) begin
            $display("unreadable register entry in test %0s", testName);
            setupErrors++;
          end else begin
            expRegs.push_back(regNum[4:0]);
            expVals.push_back(value);
          end
        end else begin
          rc = $sscanf(tok, "%h", value);
          if (rc != 1) begin
            $display("unreadable program word in test %0s", testName);
            setupErrors++;
          end else begin
            progWords.push_back(value);
          end
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, passed %0d, failed %0d", testsRun, testsRun - testsFailed,
             testsFailed);
    if (testsFailed == 0 && setupErrors == 0 && testsRun > 0 && !aborted) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/programCases.txt
# T name, P program words in hex from address 0, E pairs of register index and hex value
# X loads and runs the test, then checks the listed registers
# register ALU ops, SRA sign fill, SLT against SLTU on a negative, LUI
T alu
P FF400093 00500113 002081B3 40208233 0020F2B3 0020E333 0020C3B3 00211433 0020D4B3
P 4020D533 001125B3 00113633 0020A733 123456B7 00000073
E 1 FFFFFFF4 2 00000005 3 FFFFFFF9 4 FFFFFFEF 5 00000004 6 FFFFFFF5 7 FFFFFFF1
E 8 000000A0 9 07FFFFFF 10 FFFFFFFF 11 00000000 12 00000001 13 12345000 14 00000001
X
# immediate forms, writes to x0 dropped
T imm
P 800000B7 0F00E113 0FF17193 FFF1C213 00419293 0040D313 4040D393 0010A413 0010B493
P FFF1B593 FF018513 00518013 00208033 00000073
E 0 00000000 1 80000000 2 800000F0 3 000000F0 4 FFFFFF0F 5 00000F00 6 08000000
E 7 F8000000 8 00000001 9 00000000 10 000000E0 11 00000001
X
# dependences at distance one, two and three
T forward
P 00700093 00308113 001101B3 40218233 004202B3 00100313 0062C3B3 06428413 401384B3
P 00000073
E 1 00000007 2 0000000A 3 00000011 4 00000007 5 0000000E 6 00000001 7 0000000F
E 8 00000072 9 00000008
X
# store then load, load result used right away
T memory
P 04000093 ABCDE137 12310113 0020A223 0040A183 00118213 0040A423 0080A283 00328333
P 00000073
E 1 00000040 2 ABCDE123 3 ABCDE123 4 ABCDE124 5 ABCDE124 6 579BC247
X
# branches taken and not, jal link, nothing after ecall lands
T branch
P 00300093 00300113 00208663 00100193 00100213 00209463 00500293 FFF00313 00134663
P 00100393 00100413 00135463 00C004EF 00100513 00100593 0060D663 00100613 00100693
P 00248713 00000073 00100793 00100813 00100893
E 1 00000003 2 00000003 3 00000000 4 00000000 5 00000005 6 FFFFFFFF 7 00000000
E 8 00000000 9 00000034 10 00000000 11 00000000 12 00000000 13 00000000 14 00000036
E 15 00000000 16 00000000 17 00000000
X

// File: dv/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
verilog/cpuPkg.sv
verilog/pipeReg.sv
verilog/memSystem.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/execStage.sv
verilog/hazardUnit.sv
verilog/cpuTop.sv
dv/tbClock.sv
dv/cpuTb.sv

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // ==================================================
  // widths
  // ==================================================
  typedef logic [31:0] word_t;
  typedef logic [4:0] regAddr_t;

  localparam int MEM_WORDS = 256;
  typedef logic [$clog2(MEM_WORDS)-1:0] memIdx_t;

  typedef logic [3:0] aluOp_t;
  typedef logic [1:0] wbSel_t;
  typedef logic [1:0] fwdSel_t;
  typedef logic [1:0] hazard_t;

  // ==================================================
  // opcodes
  // ==================================================
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // addi x0, x0, 0
  localparam word_t INST_NOP = 32'h0000_0013;

  localparam aluOp_t ALU_ADD = 4'd0;
  localparam aluOp_t ALU_SUB = 4'd1;
  localparam aluOp_t ALU_AND = 4'd2;
  localparam aluOp_t ALU_OR = 4'd3;
  localparam aluOp_t ALU_XOR = 4'd4;
  localparam aluOp_t ALU_SLL = 4'd5;
  localparam aluOp_t ALU_SRL = 4'd6;
  localparam aluOp_t ALU_SRA = 4'd7;
  localparam aluOp_t ALU_SLT = 4'd8;
  localparam aluOp_t ALU_SLTU = 4'd9;
  localparam aluOp_t ALU_PASSB = 4'd10;

  localparam wbSel_t WB_ALU = 2'd0;
  localparam wbSel_t WB_MEM = 2'd1;
  localparam wbSel_t WB_PC4 = 2'd2;

  localparam fwdSel_t FWD_NONE = 2'd0;
  localparam fwdSel_t FWD_MEM = 2'd1;
  localparam fwdSel_t FWD_WB = 2'd2;

  localparam hazard_t HZ_NONE = 2'd0;
  localparam hazard_t HZ_STALL = 2'd1;
  localparam hazard_t HZ_FLUSH = 2'd2;

  // stage register payloads: words, then rd/aluOp, then flags
  localparam int ID_EX_WIDTH = 4 * 32 + 5 + 4 + 2 + 3 + 8;
  localparam int EX_MEM_WIDTH = 3 * 32 + 2 + 4;
  localparam int MEM_WB_WIDTH = 3 * 32 + 2 + 2;

  typedef enum logic {
    CORE_RUN,
    CORE_HALT
  } coreState_t;

endpackage

`default_nettype wire

// File: verilog/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   imemWrEn_i,
  input  wire cpuPkg::memIdx_t  imemWrAddr_i,
  input  wire cpuPkg::word_t    imemWrData_i,
  input  wire cpuPkg::regAddr_t dbgRegAddr_i,
  output cpuPkg::word_t         dbgRegData_o,
  output logic                  ecall_o
);

  cpuPkg::hazard_t hazard, backHazard;
  cpuPkg::fwdSel_t fwdA, fwdB;
  logic halted, haltNow;
  cpuPkg::word_t pc, pcPlus4, pcNext, fetchInst;

  cpuPkg::word_t idInst, idPc, idImm, idRs1Data, idRs2Data;
  cpuPkg::regAddr_t idRs1, idRs2, idRd;
  cpuPkg::aluOp_t idAluOp;
  cpuPkg::wbSel_t idWbSel;
  logic [2:0] idFunct3;
  logic idSrcImm, idSrcPc, idMemRead, idMemWrite, idRegWrite, idBranch, idJal, idEcall;

  cpuPkg::word_t exInst, exPc, exRs1Data, exRs2Data, exImm, exAlu, exStore, exTarget;
  cpuPkg::regAddr_t exRd;
  cpuPkg::aluOp_t exAluOp;
  cpuPkg::wbSel_t exWbSel;
  logic [2:0] exFunct3;
  logic exSrcImm, exSrcPc, exMemRead, exMemWrite, exRegWrite, exBranch, exJal, exEcall;
  logic exTaken;

  cpuPkg::word_t memInst, memPc, memAlu, memStore, memLoad;
  cpuPkg::wbSel_t memWbSel;
  logic memMemRead, memMemWrite, memRegWrite, memEcall;

  cpuPkg::word_t wbInst, wbPc, wbAlu, wbLoad, wbData;
  cpuPkg::regAddr_t wbRd;
  cpuPkg::wbSel_t wbWbSel;
  logic wbRegWrite, wbEcall;

  logic [cpuPkg::ID_EX_WIDTH-1:0] idExQ;
  logic [cpuPkg::EX_MEM_WIDTH-1:0] exMemQ;
  logic [cpuPkg::MEM_WB_WIDTH-1:0] memWbQ;

  // ==================================================
  // fetch
  // ==================================================
  // ecall in writeback freezes fetch and drains everything behind it
  assign haltNow = halted || wbEcall;
  assign backHazard = haltNow ? cpuPkg::HZ_FLUSH : cpuPkg::HZ_NONE;
  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    if (haltNow || hazard == cpuPkg::HZ_STALL) begin
      pcNext = pc;
    end else if (hazard == cpuPkg::HZ_FLUSH) begin
      pcNext = exTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  memSystem i_memSystem (
    .clk(clk), .instPc_i(pc), .inst_o(fetchInst),
    .imemWrEn_i(imemWrEn_i), .imemWrAddr_i(imemWrAddr_i), .imemWrData_i(imemWrData_i),
    .dataAddr_i(memAlu), .dataWrData_i(memStore), .dataRead_i(memMemRead),
    .dataWrite_i(memMemWrite && !haltNow), .dataRdData_o(memLoad)
  );

  // ==================================================
  // IF/ID and decode
  // ==================================================
  pipeReg #(.WIDTH(32), .RESET_VALUE(cpuPkg::INST_NOP)) i_ifIdInst (
    .clk(clk), .rst(rst), .hazard_i(hazard), .stallable_i(1'b1),
    .d_i(fetchInst), .q_o(idInst)
  );
  pipeReg #(.WIDTH(32)) i_ifIdPc (
    .clk(clk), .rst(rst), .hazard_i(hazard), .stallable_i(1'b1),
    .d_i(pc), .q_o(idPc)
  );

  decodeStage i_decodeStage (
    .inst_i(idInst), .rs1_o(idRs1), .rs2_o(idRs2), .rd_o(idRd), .imm_o(idImm),
    .aluOp_o(idAluOp), .aluSrcImm_o(idSrcImm), .aluSrcPc_o(idSrcPc),
    .memRead_o(idMemRead), .memWrite_o(idMemWrite), .regWrite_o(idRegWrite),
    .wbSel_o(idWbSel), .isBranch_o(idBranch), .brFunct3_o(idFunct3),
    .isJal_o(idJal), .isEcall_o(idEcall)
  );

  regFile i_regFile (
    .clk(clk), .rst(rst),
    .rdAddr1_i(idRs1), .rdAddr2_i(idRs2), .rdData1_o(idRs1Data), .rdData2_o(idRs2Data),
    .wrEn_i(wbRegWrite), .wrAddr_i(wbRd), .wrData_i(wbData),
    .dbgAddr_i(dbgRegAddr_i), .dbgData_o(dbgRegData_o)
  );

  // ==================================================
  // ID/EX and execute
  // ==================================================
  pipeReg #(.WIDTH(32), .RESET_VALUE(cpuPkg::INST_NOP)) i_idExInst (
    .clk(clk), .rst(rst), .hazard_i(hazard), .stallable_i(1'b0),
    .d_i(idInst), .q_o(exInst)
  );
  pipeReg #(.WIDTH(cpuPkg::ID_EX_WIDTH)) i_idExData (
    .clk(clk), .rst(rst), .hazard_i(hazard), .stallable_i(1'b0),
    .d_i({idPc, idRs1Data, idRs2Data, idImm, idRd, idAluOp, idWbSel, idFunct3,
          idSrcImm, idSrcPc, idMemRead, idMemWrite, idRegWrite, idBranch, idJal, idEcall}),
    .q_o(idExQ)
  );
  assign {exPc, exRs1Data, exRs2Data, exImm, exRd, exAluOp, exWbSel, exFunct3,
          exSrcImm, exSrcPc, exMemRead, exMemWrite, exRegWrite, exBranch, exJal, exEcall} = idExQ;

  execStage i_execStage (
    .rs1Data_i(exRs1Data), .rs2Data_i(exRs2Data), .pc_i(exPc), .imm_i(exImm),
    .aluOp_i(exAluOp), .aluSrcImm_i(exSrcImm), .aluSrcPc_i(exSrcPc),
    .isBranch_i(exBranch), .brFunct3_i(exFunct3), .isJal_i(exJal),
    .fwdA_i(fwdA), .fwdB_i(fwdB), .memResult_i(memAlu), .wbResult_i(wbData),
    .aluResult_o(exAlu), .storeData_o(exStore), .taken_o(exTaken), .target_o(exTarget)
  );

  hazardUnit i_hazardUnit (
    .clk(clk), .rst(rst),
    .idRs1_i(idRs1), .idRs2_i(idRs2), .exRd_i(exRd), .exMemRead_i(exMemRead),
    .exRs1_i(exInst[19:15]), .exRs2_i(exInst[24:20]),
    .memRd_i(memInst[11:7]), .memRegWrite_i(memRegWrite),
    .wbRd_i(wbRd), .wbRegWrite_i(wbRegWrite), .wbEcall_i(wbEcall),
    .taken_i(exTaken), .hazard_o(hazard), .fwdA_o(fwdA), .fwdB_o(fwdB), .halted_o(halted)
  );

  // ==================================================
  // EX/MEM, MEM/WB and writeback
  // ==================================================
  pipeReg #(.WIDTH(32), .RESET_VALUE(cpuPkg::INST_NOP)) i_exMemInst (
    .clk(clk), .rst(rst), .hazard_i(backHazard), .stallable_i(1'b0),
    .d_i(exInst), .q_o(memInst)
  );
  pipeReg #(.WIDTH(cpuPkg::EX_MEM_WIDTH)) i_exMemData (
    .clk(clk), .rst(rst), .hazard_i(backHazard), .stallable_i(1'b0),
    .d_i({exPc, exAlu, exStore, exWbSel, exMemRead, exMemWrite, exRegWrite, exEcall}),
    .q_o(exMemQ)
  );
  assign {memPc, memAlu, memStore, memWbSel, memMemRead, memMemWrite, memRegWrite,
          memEcall} = exMemQ;

  pipeReg #(.WIDTH(32), .RESET_VALUE(cpuPkg::INST_NOP)) i_memWbInst (
    .clk(clk), .rst(rst), .hazard_i(backHazard), .stallable_i(1'b0),
    .d_i(memInst), .q_o(wbInst)
  );
  pipeReg #(.WIDTH(cpuPkg::MEM_WB_WIDTH)) i_memWbData (
    .clk(clk), .rst(rst), .hazard_i(backHazard), .stallable_i(1'b0),
    .d_i({memPc, memLoad, memAlu, memWbSel, memRegWrite, memEcall}),
    .q_o(memWbQ)
  );
  assign {wbPc, wbLoad, wbAlu, wbWbSel, wbRegWrite, wbEcall} = memWbQ;
  assign wbRd = wbInst[11:7];

  always_comb begin
    case (wbWbSel)
      cpuPkg::WB_MEM: wbData = wbLoad;
      cpuPkg::WB_PC4: wbData = wbPc + 32'd4;
      default: wbData = wbAlu;
    endcase
  end

  assign ecall_o = halted;

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
  input  wire cpuPkg::word_t inst_i,
  output cpuPkg::regAddr_t   rs1_o,
  output cpuPkg::regAddr_t   rs2_o,
  output cpuPkg::regAddr_t   rd_o,
  output cpuPkg::word_t      imm_o,
  output cpuPkg::aluOp_t     aluOp_o,
  output logic               aluSrcImm_o,
  output logic               aluSrcPc_o,
  output logic               memRead_o,
  output logic               memWrite_o,
  output logic               regWrite_o,
  output cpuPkg::wbSel_t     wbSel_o,
  output logic               isBranch_o,
  output logic [2:0]         brFunct3_o,
  output logic               isJal_o,
  output logic               isEcall_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  cpuPkg::aluOp_t fieldOp;
  cpuPkg::word_t immI, immS, immB, immU, immJ;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign brFunct3_o = funct3;

  assign immI = {{20{inst_i[31]}}, inst_i[31:20]};
  assign immS = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign immB = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign immU = {inst_i[31:12], 12'b0};
  assign immJ = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // ALU op from funct3, bit 30 picks SUB and SRA
  always_comb begin
    case (funct3)
      3'b000: fieldOp = (opcode == cpuPkg::OP_REG && inst_i[30]) ? cpuPkg::ALU_SUB
                                                                    : cpuPkg::ALU_ADD;
      3'b001: fieldOp = cpuPkg::ALU_SLL;
      3'b010: fieldOp = cpuPkg::ALU_SLT;
      3'b011: fieldOp = cpuPkg::ALU_SLTU;
      3'b100: fieldOp = cpuPkg::ALU_XOR;
      3'b101: fieldOp = inst_i[30] ? cpuPkg::ALU_SRA : cpuPkg::ALU_SRL;
      3'b110: fieldOp = cpuPkg::ALU_OR;
      default: fieldOp = cpuPkg::ALU_AND;
    endcase
  end

  always_comb begin
    // unknown opcodes fall out as a nop
    rs1_o = '0;
    rs2_o = '0;
    rd_o = inst_i[11:7];
    imm_o = '0;
    aluOp_o = cpuPkg::ALU_ADD;
    aluSrcImm_o = 1'b0;
    aluSrcPc_o = 1'b0;
    memRead_o = 1'b0;
    memWrite_o = 1'b0;
    regWrite_o = 1'b0;
    wbSel_o = cpuPkg::WB_ALU;
    isBranch_o = 1'b0;
    isJal_o = 1'b0;
    isEcall_o = 1'b0;
    case (opcode)
      cpuPkg::OP_REG: begin
        rs1_o = inst_i[19:15];
        rs2_o = inst_i[24:20];
        aluOp_o = fieldOp;
        regWrite_o = 1'b1;
      end
      cpuPkg::OP_IMM: begin
        rs1_o = inst_i[19:15];
        imm_o = immI;
        aluSrcImm_o = 1'b1;
        aluOp_o = fieldOp;
        regWrite_o = 1'b1;
      end
      cpuPkg::OP_LUI: begin
        imm_o = immU;
        aluSrcImm_o = 1'b1;
        aluOp_o = cpuPkg::ALU_PASSB;
        regWrite_o = 1'b1;
      end
      cpuPkg::OP_LOAD: begin
        rs1_o = inst_i[19:15];
        imm_o = immI;
        aluSrcImm_o = 1'b1;
        memRead_o = 1'b1;
        regWrite_o = 1'b1;
        wbSel_o = cpuPkg::WB_MEM;
      end
      cpuPkg::OP_STORE: begin
        rs1_o = inst_i[19:15];
        rs2_o = inst_i[24:20];
        imm_o = immS;
        aluSrcImm_o = 1'b1;
        memWrite_o = 1'b1;
      end
      cpuPkg::OP_BRANCH: begin
        rs1_o = inst_i[19:15];
        rs2_o = inst_i[24:20];
        imm_o = immB;
        isBranch_o = 1'b1;
      end
      cpuPkg::OP_JAL: begin
        imm_o = immJ;
        aluSrcPc_o = 1'b1;
        aluSrcImm_o = 1'b1;
        isJal_o = 1'b1;
        regWrite_o = 1'b1;
        wbSel_o = cpuPkg::WB_PC4;
      end
      cpuPkg::OP_SYSTEM: isEcall_o = 1'b1;
      default: ;
    endcase
    // x0 is never written
    if (rd_o == '0) begin
      regWrite_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/execStage.sv
`timescale 1ns/100ps
`default_nettype none

module execStage (
  input  wire cpuPkg::word_t   rs1Data_i,
  input  wire cpuPkg::word_t   rs2Data_i,
  input  wire cpuPkg::word_t   pc_i,
  input  wire cpuPkg::word_t   imm_i,
  input  wire cpuPkg::aluOp_t  aluOp_i,
  input  wire                  aluSrcImm_i,
  input  wire                  aluSrcPc_i,
  input  wire                  isBranch_i,
  input  wire [2:0]            brFunct3_i,
  input  wire                  isJal_i,
  input  wire cpuPkg::fwdSel_t fwdA_i,
  input  wire cpuPkg::fwdSel_t fwdB_i,
  input  wire cpuPkg::word_t   memResult_i,
  input  wire cpuPkg::word_t   wbResult_i,
  output cpuPkg::word_t        aluResult_o,
  output cpuPkg::word_t        storeData_o,
  output logic                 taken_o,
  output cpuPkg::word_t        target_o
);

  cpuPkg::word_t srcA, srcB, opA, opB;
  logic brEq, brLt, brCond;

  function automatic cpuPkg::word_t pickFwd(cpuPkg::fwdSel_t sel, cpuPkg::word_t regVal,
                                            cpuPkg::word_t memVal, cpuPkg::word_t wbVal);
    case (sel)
      cpuPkg::FWD_MEM: return memVal;
      cpuPkg::FWD_WB: return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign srcA = pickFwd(fwdA_i, rs1Data_i, memResult_i, wbResult_i);
  assign srcB = pickFwd(fwdB_i, rs2Data_i, memResult_i, wbResult_i);
  assign opA = aluSrcPc_i ? pc_i : srcA;
  assign opB = aluSrcImm_i ? imm_i : srcB;
  assign storeData_o = srcB;

  always_comb begin
    case (aluOp_i)
      cpuPkg::ALU_SUB: aluResult_o = opA - opB;
      cpuPkg::ALU_AND: aluResult_o = opA & opB;
      cpuPkg::ALU_OR: aluResult_o = opA | opB;
      cpuPkg::ALU_XOR: aluResult_o = opA ^ opB;
      cpuPkg::ALU_SLL: aluResult_o = opA << opB[4:0];
      cpuPkg::ALU_SRL: aluResult_o = opA >> opB[4:0];
      cpuPkg::ALU_SRA: aluResult_o = $signed(opA) >>> opB[4:0];
      cpuPkg::ALU_SLT: aluResult_o = {31'b0, $signed(opA) < $signed(opB)};
      cpuPkg::ALU_SLTU: aluResult_o = {31'b0, opA < opB};
      cpuPkg::ALU_PASSB: aluResult_o = opB;
      default: aluResult_o = opA + opB;
    endcase
  end

  // beq/bne on equality, blt/bge on signed less-than, bit 0 inverts
  assign brEq = srcA == srcB;
  assign brLt = $signed(srcA) < $signed(srcB);
  assign brCond = brFunct3_i[2] ? (brLt ^ brFunct3_i[0]) : (brEq ^ brFunct3_i[0]);

  assign taken_o = isJal_i || (isBranch_i && brCond);
  assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
  input  wire                   clk,
  input  wire                   rst,
  input  wire cpuPkg::regAddr_t idRs1_i,
  input  wire cpuPkg::regAddr_t idRs2_i,
  input  wire cpuPkg::regAddr_t exRd_i,
  input  wire                   exMemRead_i,
  input  wire cpuPkg::regAddr_t exRs1_i,
  input  wire cpuPkg::regAddr_t exRs2_i,
  input  wire cpuPkg::regAddr_t memRd_i,
  input  wire                   memRegWrite_i,
  input  wire cpuPkg::regAddr_t wbRd_i,
  input  wire                   wbRegWrite_i,
  input  wire                   wbEcall_i,
  input  wire                   taken_i,
  output cpuPkg::hazard_t       hazard_o,
  output cpuPkg::fwdSel_t       fwdA_o,
  output cpuPkg::fwdSel_t       fwdB_o,
  output logic                  halted_o
);

  cpuPkg::coreState_t state;
  logic loadUse;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cpuPkg::CORE_RUN;
    end else if (wbEcall_i) begin
      state <= cpuPkg::CORE_HALT;
    end
  end

  assign halted_o = state == cpuPkg::CORE_HALT;

  // load in EX feeding the instruction in decode
  assign loadUse = exMemRead_i && exRd_i != '0 &&
                   (exRd_i == idRs1_i || exRd_i == idRs2_i);

  always_comb begin
    if (halted_o || wbEcall_i || taken_i) begin
      hazard_o = cpuPkg::HZ_FLUSH;
    end else if (loadUse) begin
      hazard_o = cpuPkg::HZ_STALL;
    end else begin
      hazard_o = cpuPkg::HZ_NONE;
    end
  end

  // newest producer wins
  function automatic cpuPkg::fwdSel_t pickSrc(cpuPkg::regAddr_t rs);
    if (rs == '0) begin
      return cpuPkg::FWD_NONE;
    end else if (memRegWrite_i && memRd_i == rs) begin
      return cpuPkg::FWD_MEM;
    end else if (wbRegWrite_i && wbRd_i == rs) begin
      return cpuPkg::FWD_WB;
    end
    return cpuPkg::FWD_NONE;
  endfunction

  assign fwdA_o = pickSrc(exRs1_i);
  assign fwdB_o = pickSrc(exRs2_i);

endmodule

`default_nettype wire

// File: verilog/memSystem.sv
`timescale 1ns/100ps
`default_nettype none

module memSystem (
  input  wire                  clk,
  input  wire cpuPkg::word_t   instPc_i,
  output cpuPkg::word_t        inst_o,
  input  wire                  imemWrEn_i,
  input  wire cpuPkg::memIdx_t imemWrAddr_i,
  input  wire cpuPkg::word_t   imemWrData_i,
  input  wire cpuPkg::word_t   dataAddr_i,
  input  wire cpuPkg::word_t   dataWrData_i,
  input  wire                  dataRead_i,
  input  wire                  dataWrite_i,
  output cpuPkg::word_t        dataRdData_o
);

  cpuPkg::word_t instMem [cpuPkg::MEM_WORDS];
  cpuPkg::word_t dataMem [cpuPkg::MEM_WORDS];
  cpuPkg::memIdx_t instIdx;
  cpuPkg::memIdx_t dataIdx;

  // byte address to word index, upper bits dropped
  assign instIdx = instPc_i[2 +: $bits(cpuPkg::memIdx_t)];
  assign dataIdx = dataAddr_i[2 +: $bits(cpuPkg::memIdx_t)];

  // program load port
  always_ff @(posedge clk) begin
    if (imemWrEn_i) begin
      instMem[imemWrAddr_i] <= imemWrData_i;
    end
  end

  always_ff @(posedge clk) begin
    if (dataWrite_i) begin
      dataMem[dataIdx] <= dataWrData_i;
    end
  end

  assign inst_o = instMem[instIdx];
  assign dataRdData_o = dataRead_i ? dataMem[dataIdx] : '0;

endmodule

`default_nettype wire

// File: verilog/pipeReg.sv
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
  parameter int WIDTH = 32,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire cpuPkg::hazard_t hazard_i,
  input  wire                  stallable_i,
  input  wire [WIDTH-1:0]      d_i,
  output logic [WIDTH-1:0]     q_o
);

  always_ff @(posedge clk) begin
    if (rst || hazard_i == cpuPkg::HZ_FLUSH) begin
      q_o <= RESET_VALUE;
    end else if (hazard_i == cpuPkg::HZ_STALL) begin
      // stallable stages hold, the stage behind them takes a bubble
      if (!stallable_i) begin
        q_o <= RESET_VALUE;
      end
    end else begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  wire                   clk,
  input  wire                   rst,
  input  wire cpuPkg::regAddr_t rdAddr1_i,
  input  wire cpuPkg::regAddr_t rdAddr2_i,
  output cpuPkg::word_t         rdData1_o,
  output cpuPkg::word_t         rdData2_o,
  input  wire                   wrEn_i,
  input  wire cpuPkg::regAddr_t wrAddr_i,
  input  wire cpuPkg::word_t    wrData_i,
  input  wire cpuPkg::regAddr_t dbgAddr_i,
  output cpuPkg::word_t         dbgData_o
);

  cpuPkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn_i && wrAddr_i != '0) begin
      regs[wrAddr_i] <= wrData_i;
    end
  end

  // writeback in the same cycle goes straight to decode
  assign rdData1_o = (rdAddr1_i == '0) ? '0 :
                     (wrEn_i && wrAddr_i == rdAddr1_i) ? wrData_i : regs[rdAddr1_i];
  assign rdData2_o = (rdAddr2_i == '0) ? '0 :
                     (wrEn_i && wrAddr_i == rdAddr2_i) ? wrData_i : regs[rdAddr2_i];

  // debug view has no bypass
  assign dbgData_o = regs[dbgAddr_i];

endmodule

`default_nettype wire
